/* uart_settings.svh */
// compile-time settings for the uart peripheral
// frame size, oversampling, fifo sizing and baud divisor
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

//////////////////////////////////////////////////
// serial frame
//////////////////////////////////////////////////

`define dataBits		8	// fixed 8N1 frame
`define ticksPerBit		16	// 16x oversampling
`define sbTick			16	// ticks in the stop bit, one stop bit

//////////////////////////////////////////////////
// fifos
//////////////////////////////////////////////////

`define fifoDepth		16	// entries per fifo
`define fifoCntrWidth	5	// count has to hold 0..fifoDepth

//////////////////////////////////////////////////
// baud rate
//////////////////////////////////////////////////

// clk cycles per oversampling tick
// bit time = clksPerTick * ticksPerBit clk cycles, 64 with the default
`define clksPerTick		4

`endif

/* uartLinePkg.sv */
// serial side types
// data byte on the line and the word handed from receiver to rx fifo
`include "uart_settings.svh"

package uartLinePkg;

	//////////////////////////////////////////////////
	// byte as it travels on tx / rx
	//////////////////////////////////////////////////

	typedef logic [`dataBits-1:0] dataByte;	// one frame payload

	//////////////////////////////////////////////////
	// received word
	//////////////////////////////////////////////////

	// payload of the receive fifo
	// frameErr rides along with its own byte so the host can
	// tell which entry had a bad stop bit
	typedef struct packed
	{
		dataByte	data;		// sampled data bits, lsb first on the wire
		logic		frameErr;	// stop sample read low
	} rxWord;

endpackage

/* uartHostPkg.sv */
// host side types
// command enum, request / response structs, status byte

package uartHostPkg;

	// three host commands, value 3 unused
	typedef enum logic [1:0]
	{
		CMD_READ	= 2'd0,	// pop a received byte
		CMD_WRITE	= 2'd1,	// push a byte to send
		CMD_STAT	= 2'd2	// read status, clears sticky flags
	} hostCmd;

	typedef struct packed
	{
		hostCmd					cmd;
		uartLinePkg::dataByte	wrData;	// only meaningful for CMD_WRITE
	} hostReq;

	typedef struct packed
	{
		uartLinePkg::dataByte	rdData;	// head byte or status
	} hostRsp;

	// status byte, msb first
	typedef struct packed
	{
		logic	spare;		// reads as zero
		logic	rxWordErr;	// frame error of the rx head entry
		logic	overrun;	// sticky, word dropped on full rx fifo
		logic	frameErr;	// sticky, bad stop bit seen
		logic	rxFull;
		logic	rxEmpty;
		logic	txFull;
		logic	txEmpty;
	} uartStatus;

endpackage

/* baudTickGen.sv */
// baud tick generator
// one-cycle tick every DIVISOR clk cycles, 16 ticks per bit
`timescale 1ns/1ns
`include "uart_settings.svh"

module baudTickGen
#(
	parameter int DIVISOR = `clksPerTick
)
(
	input	logic	clk,
	input	logic	reset,
	output	logic	tick
);

	localparam int cntWidth = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

	logic [cntWidth-1:0] cnt;	// free running, wraps at DIVISOR-1

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= '0;
		else if (tick)
			cnt <= '0;	// wrap
		else
			cnt <= cnt + 1'b1;
	end

	assign tick = (cnt == cntWidth'(DIVISOR - 1));	// last count of the period

	// with DIVISOR of 1 the tick is simply always high
	generate
		if (DIVISOR > 1)
		begin : gTickCheck
			assert property (@(posedge clk) disable iff (reset) tick |=> !tick);
		end
	endgenerate

endmodule

/* uartFifo.sv */
// show-ahead fifo, payload type set by parameter
// circular buffer, valid/ready on both sides, occupancy count
`timescale 1ns/1ns
`include "uart_settings.svh"

module uartFifo
#(
	parameter type T = logic [7:0],
	parameter int DEPTH = `fifoDepth
)
(
	input	logic						clk,
	input	logic						reset,
	input	T							inData,
	input	logic						inValid,
	output	logic						inReady,
	output	T							outData,
	output	logic						outValid,
	input	logic						outReady,
	output	logic [`fifoCntrWidth-1:0]	count
);

	localparam int ptrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T mem [DEPTH];	// storage, no reset
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic push;
	logic pop;

	// pointer increment with wrap for any depth
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] p);
		return (p == ptrWidth'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign inReady = (count != `fifoCntrWidth'(DEPTH));	// not full
	assign outValid = (count != '0);	// not empty
	assign push = inValid && inReady;
	assign pop = outValid && outReady;
	assign outData = mem[rdPtr];	// head shown ahead of the pop

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= inData;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;	// idle or push+pop
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) count <= `fifoCntrWidth'(DEPTH));
	// head must hold while the consumer stalls
	assert property (@(posedge clk) disable iff (reset)
		(outValid && !outReady) |=> $stable(outData));

endmodule

/* uartTrans.sv */
// serial transmitter, 8N1
// fsm idle / start / data / stop, lsb first, registered tx
`timescale 1ns/1ns
`include "uart_settings.svh"

module uartTrans
(
	input	logic					clk,
	input	logic					reset,
	input	logic					tick,		// 16x oversampling strobe
	input	uartLinePkg::dataByte	inData,
	input	logic					inValid,
	output	logic					inReady,
	output	logic					tx
);

	localparam int tickWidth = $clog2((`sbTick > `ticksPerBit) ? `sbTick : `ticksPerBit);
	localparam int bitWidth = $clog2(`dataBits);

	typedef enum logic [1:0] {sIdle, sStart, sData, sStop} txState;

	txState state;
	logic [tickWidth-1:0] tickCnt;	// ticks inside the current bit
	logic [bitWidth-1:0] bitCnt;	// data bit index
	uartLinePkg::dataByte shReg;	// byte being shifted out
	logic txReg;
	logic load;
	logic bitEnd;
	logic stopEnd;

	assign inReady = (state == sIdle);	// byte taken on the transfer edge
	assign load = inValid && inReady;
	assign bitEnd = tick && (tickCnt == tickWidth'(`ticksPerBit - 1));
	assign stopEnd = tick && (tickCnt == tickWidth'(`sbTick - 1));

	//////////////////////////////////////////////////
	// shift register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (load)
			shReg <= inData;
		else if ((state == sData) && bitEnd)
			shReg <= shReg >> 1;	// next bit into [0]
	end

	//////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= sIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			case (state)
				sIdle:
				begin
					tickCnt <= '0;
					if (load)
					begin
						txReg <= 1'b0;	// start bit goes out with the state
						state <= sStart;
					end
				end
				sStart:
				begin
					if (bitEnd)
					begin
						tickCnt <= '0;
						bitCnt <= '0;
						txReg <= shReg[0];	// first data bit
						state <= sData;
					end
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
				sData:
				begin
					if (bitEnd)
					begin
						tickCnt <= '0;
						if (bitCnt == bitWidth'(`dataBits - 1))
						begin
							txReg <= 1'b1;	// stop bit
							state <= sStop;
						end
						else
						begin
							bitCnt <= bitCnt + 1'b1;
							txReg <= shReg[1];	// the bit about to shift into [0]
						end
					end
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
				sStop:
				begin
					if (stopEnd)
						state <= sIdle;	// ready again on this tick
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
			endcase
		end
	end

	assign tx = txReg;

	assert property (@(posedge clk) disable iff (reset) (state == sIdle) |-> tx);
	assert property (@(posedge clk) disable iff (reset) (state == sStart) |-> !tx);
	// ready drops only on a transfer, returns only on a tick
	assert property (@(posedge clk) disable iff (reset) $fell(inReady) |-> $past(inValid));
	assert property (@(posedge clk) disable iff (reset) $rose(inReady) |-> $past(tick));

endmodule

/* uartRecv.sv */
// oversampling serial receiver, 8N1
// 2-flop sync, start confirm at mid-bit, centre sampling, stop check
`timescale 1ns/1ns
`include "uart_settings.svh"

module uartRecv
(
	input	logic					clk,
	input	logic					reset,
	input	logic					tick,
	input	logic					rx,
	output	uartLinePkg::rxWord		word,
	output	logic					wordValid	// one cycle, no ready
);

	localparam int tickWidth = $clog2(`ticksPerBit);
	localparam int bitWidth = $clog2(`dataBits);

	typedef enum logic [1:0] {sIdle, sStart, sData, sStop} rxState;

	rxState state;
	logic rxMeta;	// first sync stage
	logic rxSync;	// second sync stage, safe to use
	logic rxPrev;	// for edge detect
	logic [tickWidth-1:0] tickCnt;
	logic [bitWidth-1:0] bitCnt;
	uartLinePkg::dataByte shReg;	// collects bits, lsb arrives first
	logic midEnd;
	logic bitEnd;

	assign midEnd = tick && (tickCnt == tickWidth'(`ticksPerBit / 2 - 1));	// half a bit
	assign bitEnd = tick && (tickCnt == tickWidth'(`ticksPerBit - 1));	// a full bit

	//////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if ((state == sData) && bitEnd)
			shReg <= {rxSync, shReg[`dataBits-1:1]};	// shift in from the top
		if ((state == sStop) && bitEnd)
		begin
			word.data <= shReg;
			word.frameErr <= !rxSync;	// stop must read high
		end
	end

	//////////////////////////////////////////////////
	// sync + fsm
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
			state <= sIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			wordValid <= 1'b0;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
			wordValid <= 1'b0;	// pulse default
			case (state)
				sIdle:
				begin
					tickCnt <= '0;
					if (rxPrev && !rxSync)	// falling edge, maybe a start bit
						state <= sStart;
				end
				sStart:
				begin
					if (midEnd)
					begin
						tickCnt <= '0;
						bitCnt <= '0;
						state <= rxSync ? sIdle : sData;	// glitch goes back to idle
					end
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
				sData:
				begin
					if (bitEnd)
					begin
						tickCnt <= '0;
						if (bitCnt == bitWidth'(`dataBits - 1))
							state <= sStop;
						else
							bitCnt <= bitCnt + 1'b1;
					end
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
				sStop:
				begin
					if (bitEnd)	// middle of the stop bit
					begin
						wordValid <= 1'b1;
						state <= sIdle;
					end
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (reset) wordValid |=> !wordValid);

endmodule

/* uartPeripheral.sv */
// uart peripheral top
// host command decode, status byte, sticky flags, block instances
`timescale 1ns/1ns
`include "uart_settings.svh"

module uartPeripheral
(
	input	logic					clk,
	input	logic					reset,
	input	uartHostPkg::hostReq	req,
	input	logic					reqValid,
	output	logic					reqReady,
	output	uartHostPkg::hostRsp	rsp,
	output	logic					rspValid,
	output	logic					tx,
	input	logic					rx
);

	logic tick;
	uartLinePkg::dataByte txData;	// tx fifo head
	logic txValid;
	logic txReady;
	logic txInReady;
	logic txPush;
	logic [`fifoCntrWidth-1:0] txCount;
	uartLinePkg::rxWord rxWordIn;	// receiver -> rx fifo
	uartLinePkg::rxWord rxHead;
	logic rxWordValid;
	logic rxInReady;
	logic rxValid;
	logic rxPop;
	logic [`fifoCntrWidth-1:0] rxCount;
	logic isRead;
	logic isWrite;
	logic isStat;
	logic accept;
	logic frameErrReg;	// sticky
	logic overrunReg;	// sticky
	uartHostPkg::uartStatus status;

	//////////////////////////////////////////////////
	// command decode
	//////////////////////////////////////////////////

	assign isRead = (req.cmd == uartHostPkg::CMD_READ);
	assign isWrite = (req.cmd == uartHostPkg::CMD_WRITE);
	assign isStat = (req.cmd == uartHostPkg::CMD_STAT);
	assign txPush = reqValid && isWrite;
	assign rxPop = reqValid && isRead;	// fifo pops only when it has data
	assign accept = reqValid && reqReady;

	always_comb
	begin
		if (isWrite)
			reqReady = txInReady;
		else if (isRead)
			reqReady = rxValid;
		else
			reqReady = 1'b1;	// status, unused code just gets consumed
	end

	always_comb
	begin
		status = '0;	// spare reads zero
		status.txEmpty = (txCount == '0);
		status.txFull = !txInReady;
		status.rxEmpty = !rxValid;
		status.rxFull = (rxCount == `fifoCntrWidth'(`fifoDepth));
		status.frameErr = frameErrReg;
		status.overrun = overrunReg;
		status.rxWordErr = rxValid && rxHead.frameErr;
	end

	//////////////////////////////////////////////////
	// response and sticky flags
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (accept)
			rsp.rdData <= isRead ? rxHead.data : uartLinePkg::dataByte'(status);
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rspValid <= 1'b0;
			frameErrReg <= 1'b0;
			overrunReg <= 1'b0;
		end
		else
		begin
			rspValid <= accept && (isRead || isStat);	// writes are silent
			// a new event wins over a clear in the same cycle
			if (rxWordValid && rxInReady && rxWordIn.frameErr)
				frameErrReg <= 1'b1;
			else if (accept && isStat)
				frameErrReg <= 1'b0;
			if (rxWordValid && !rxInReady)	// dropped word
				overrunReg <= 1'b1;
			else if (accept && isStat)
				overrunReg <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	baudTickGen #(.DIVISOR(`clksPerTick)) tickGen
	(
		.clk(clk), .reset(reset), .tick(tick)
	);

	uartFifo #(.T(uartLinePkg::dataByte), .DEPTH(`fifoDepth)) txFifo
	(
		.clk(clk), .reset(reset),
		.inData(req.wrData), .inValid(txPush), .inReady(txInReady),
		.outData(txData), .outValid(txValid), .outReady(txReady),
		.count(txCount)
	);

	uartFifo #(.T(uartLinePkg::rxWord), .DEPTH(`fifoDepth)) rxFifo
	(
		.clk(clk), .reset(reset),
		.inData(rxWordIn), .inValid(rxWordValid), .inReady(rxInReady),
		.outData(rxHead), .outValid(rxValid), .outReady(rxPop),
		.count(rxCount)
	);

	uartTrans trans
	(
		.clk(clk), .reset(reset), .tick(tick),
		.inData(txData), .inValid(txValid), .inReady(txReady), .tx(tx)
	);

	uartRecv recv
	(
		.clk(clk), .reset(reset), .tick(tick), .rx(rx),
		.word(rxWordIn), .wordValid(rxWordValid)
	);

	// every response traces back to an accepted read or status request
	assert property (@(posedge clk) disable iff (reset)
		rspValid |-> $past(accept && !isWrite));

endmodule

/* uartPeripheral_tb.sv */
// testbench for the uart peripheral
// lcg data, loopback or forced rx line, tx line monitor
// checks by assertion, error counts in the closing line
`timescale 1ns/1ns
`include "uart_settings.svh"

module uartPeripheral_tb;

	localparam int bitClks = 64;		// clk cycles per bit on the line
	localparam int reqTimeout = 2000;	// cycles a request may wait for reqReady
	localparam int rxPolls = 1500;		// status polls while waiting for a byte
	localparam logic [31:0] seed = 32'h356ac2c4;

	logic clk;
	logic reset;
	uartHostPkg::hostReq req;
	logic reqValid;
	logic reqReady;
	uartHostPkg::hostRsp rsp;
	logic rspValid;
	logic tx;
	logic rx;
	logic forceMode;	// 1 = rx from sendFrame, 0 = loopback
	logic forcedRx;
	int errors;
	int timeouts;
	int stallCycles;	// cycles the last request waited
	logic [31:0] lcgState;
	logic [7:0] expQ[$];	// bytes due back from the rx fifo
	logic [7:0] monQ[$];	// bytes due on tx

	assign rx = forceMode ? forcedRx : tx;

	uartPeripheral uut
	(
		.clk(clk), .reset(reset), .req(req), .reqValid(reqValid), .reqReady(reqReady),
		.rsp(rsp), .rspValid(rspValid), .tx(tx), .rx(rx)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;	// 8 ns period
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic randomByte(output logic [7:0] b);
		lcgState = lcgStep(lcgState);
		b = lcgState[23:16];	// upper bits vary more
	endtask

	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] gotVal);
		assert (gotVal == expVal)
		else
		begin
			$display("ERR %s exp=%0h got=%0h", name, expVal, gotVal);
			errors++;
		end
	endtask

	// expected status byte, built field by field
	function automatic uartHostPkg::uartStatus expStatus(input logic txEmpty, input logic txFull,
		input logic rxEmpty, input logic rxFull, input logic frameErr, input logic overrun,
		input logic wordErr);
		uartHostPkg::uartStatus s;
		s = '0;
		s.txEmpty = txEmpty;
		s.txFull = txFull;
		s.rxEmpty = rxEmpty;
		s.rxFull = rxFull;
		s.frameErr = frameErr;
		s.overrun = overrun;
		s.rxWordErr = wordErr;
		return s;
	endfunction

	// one host request, waits for reqReady, collects the response
	task automatic hostAccess(input uartHostPkg::hostCmd cmd, input logic [7:0] wrData,
		output logic [7:0] rdData);
		int waitCnt;
		logic granted;
		waitCnt = 0;
		granted = 1'b0;
		rdData = '0;
		@(posedge clk);
		#1;
		req.cmd = cmd;
		req.wrData = wrData;
		reqValid = 1'b1;
		while (!granted && waitCnt < reqTimeout)
		begin
			#2;
			granted = reqReady;	// transfer on the coming edge
			@(posedge clk);
			#1;
			waitCnt++;
		end
		reqValid = 1'b0;
		stallCycles = waitCnt - 1;
		if (!granted)
		begin
			$display("timeout: request with command %0d was never accepted", cmd);
			timeouts++;
		end
		else if (cmd != uartHostPkg::CMD_WRITE)
		begin
			#2;
			checkValue("rspValid", 1, rspValid);
			rdData = rsp.rdData;
			@(posedge clk);
			#3;
			checkValue("rspValid", 0, rspValid);	// single cycle
		end
	endtask

	task automatic readStatus(output uartHostPkg::uartStatus st);
		logic [7:0] d;
		hostAccess(uartHostPkg::CMD_STAT, 8'h00, d);
		st = uartHostPkg::uartStatus'(d);
	endtask

	task automatic writeByte(input logic [7:0] b);
		logic [7:0] d;
		hostAccess(uartHostPkg::CMD_WRITE, b, d);
		monQ.push_back(b);
		expQ.push_back(b);	// loops back
	endtask

	task automatic readByte();
		logic [7:0] d;
		hostAccess(uartHostPkg::CMD_READ, 8'h00, d);
		if (expQ.size() == 0)
		begin
			$display("read returned a byte that was never sent");
			errors++;
		end
		else
			checkValue("rdData", expQ.pop_front(), d);
	endtask

	// poll status until the rx fifo has data
	task automatic waitRxData(output uartHostPkg::uartStatus st);
		int polls;
		polls = 0;
		readStatus(st);
		while (st.rxEmpty && polls < rxPolls)
		begin
			readStatus(st);
			polls++;
		end
		if (st.rxEmpty)
		begin
			$display("timeout: no received byte showed up in the rx fifo");
			timeouts++;
		end
	endtask

	// serialize one frame on the forced line, then two idle bits
	task automatic sendFrame(input logic [7:0] data, input logic stopBit);
		logic [9:0] frame;
		frame = {stopBit, data, 1'b0};	// start in bit 0
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			#1;
			forcedRx = frame[i];
			repeat (bitClks - 1) @(posedge clk);
		end
		@(posedge clk);
		#1;
		forcedRx = 1'b1;
		repeat (2 * bitClks - 1) @(posedge clk);
	endtask

	//////////////////////////////////////////////////
	// checks running alongside
	//////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (reset) rspValid |=> !rspValid)
	else
	begin
		$display("rspValid stayed high for two cycles");
		errors++;
	end

	assert property (@(posedge clk) disable iff (reset) $rose(rspValid) |-> $past(reqValid && reqReady))
	else
	begin
		$display("a response came without an accepted request");
		errors++;
	end

	// tx monitor, samples each frame at bit centres
	initial
	begin : txMonitor
		logic prevTx;
		logic [7:0] got;
		prevTx = 1'b1;
		forever
		begin
			@(posedge clk);
			#3;
			if (!reset && prevTx && !tx)
			begin
				repeat (bitClks / 2) @(posedge clk);
				#3;
				checkValue("tx start bit", 0, tx);
				for (int i = 0; i < 8; i++)
				begin
					repeat (bitClks) @(posedge clk);
					#3;
					got[i] = tx;	// lsb first
				end
				if (monQ.size() == 0)
				begin
					$display("a frame appeared on tx with no byte written");
					errors++;
				end
				else
					checkValue("tx data", monQ.pop_front(), got);
				repeat (bitClks) @(posedge clk);
				#3;
				checkValue("tx stop bit", 1, tx);
			end
			prevTx = tx;
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin : mainSeq
		logic [7:0] b;
		uartHostPkg::uartStatus st;
		reset = 1'b1;
		req = '0;
		reqValid = 1'b0;
		forceMode = 1'b0;
		forcedRx = 1'b1;
		errors = 0;
		timeouts = 0;
		stallCycles = 0;
		lcgState = seed;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// reset state
		checkValue("tx", 1, tx);
		checkValue("rspValid", 0, rspValid);
		readStatus(st);
		checkValue("status", expStatus(1, 0, 1, 0, 0, 0, 0), st);

		// loopback order
		for (int i = 0; i < 12; i++)
		begin
			randomByte(b);
			writeByte(b);
		end
		for (int i = 0; i < 12; i++)
		begin
			waitRxData(st);
			checkValue("rxWordErr", 0, st.rxWordErr);
			readByte();
		end

		// back-pressure, one byte in the transmitter plus 16 queued
		for (int i = 0; i < 17; i++)
		begin
			randomByte(b);
			writeByte(b);
		end
		readStatus(st);
		checkValue("status", expStatus(0, 1, 1, 0, 0, 0, 0), st);
		randomByte(b);
		writeByte(b);	// 18th, has to wait
		assert (stallCycles > 0)
		else
		begin
			$display("reqReady never held off the write into a full tx fifo");
			errors++;
		end
		for (int i = 0; i < 18; i++)
		begin
			waitRxData(st);
			readByte();
		end

		// framing error on the forced line
		repeat (bitClks) @(posedge clk);	// last stop bit done
		#1;
		forceMode = 1'b1;
		randomByte(b);
		expQ.push_back(b);
		sendFrame(b, 1'b0);	// stop bit low
		waitRxData(st);
		checkValue("status", expStatus(1, 0, 0, 0, 1, 0, 1), st);
		readByte();
		readStatus(st);
		checkValue("status", expStatus(1, 0, 1, 0, 0, 0, 0), st);

		// overrun, 17 frames into 16 entries
		for (int i = 0; i < 17; i++)
		begin
			randomByte(b);
			expQ.push_back(b);
			sendFrame(b, 1'b1);
		end
		readStatus(st);
		checkValue("status", expStatus(1, 0, 0, 1, 0, 1, 0), st);
		for (int i = 0; i < 16; i++)
			readByte();
		b = expQ.pop_front();	// dropped word
		readStatus(st);
		checkValue("status", expStatus(1, 0, 1, 0, 0, 0, 0), st);

		checkValue("tx frames not seen", 0, monQ.size());
		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* uartPeripheral.f */
+incdir+.
uartLinePkg.sv
uartHostPkg.sv
baudTickGen.sv
uartFifo.sv
uartTrans.sv
uartRecv.sv
uartPeripheral.sv
uartPeripheral_tb.sv

/* Makefile */
# Verilator build and run of the uart peripheral testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = uartPeripheral_tb
FILELIST  = uartPeripheral.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, look for the pass message in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
